// File: hdl/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// datapath and pc width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// no compressed instructions, so the pc always moves by a full word
`define PC_STEP 4

// base opcodes kept by this stage
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

// funct7 values for the shift and add/sub pairs
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000

`endif

// File: hdl/rv_decode_pkg.sv
`default_nettype none
`include "rv_decode_macros.svh"

package rv_decode_pkg;

  // R view, also used for opcode and funct fields of every format
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_t;

  typedef struct packed {
    logic [11:0]            imm_11_0;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_t;

  typedef struct packed {
    logic [6:0]             imm_11_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_4_0;
    logic [6:0]             opcode;
  } s_t;

  typedef struct packed {
    logic                   imm_12;
    logic [5:0]             imm_10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm_4_1;
    logic                   imm_11;
    logic [6:0]             opcode;
  } b_t;

  typedef struct packed {
    logic [19:0]            imm_31_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_t;

  typedef struct packed {
    logic                   imm_20;
    logic [9:0]             imm_10_1;
    logic                   imm_11;
    logic [7:0]             imm_19_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } j_t;

  typedef union packed {
    r_t r;
    i_t i;
    s_t s;
    b_t b;
    u_t u;
    j_t j;
  } instr_u;

  typedef enum logic [2:0] {
    class_alu, class_load, class_store, class_branch, class_jump, class_illegal
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    cond_beq  = 3'b000,
    cond_bne  = 3'b001,
    cond_blt  = 3'b100,
    cond_bge  = 3'b101,
    cond_bltu = 3'b110,
    cond_bgeu = 3'b111
  } branch_cond_e;

  typedef enum logic [1:0] {
    jump_none, jump_jal, jump_jalr
  } jump_kind_e;

endpackage

`default_nettype wire

// File: hdl/decode_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module decode_control (
  input  var logic clk,
  input  var logic reset,
  input  var logic in_valid,
  input  var logic out_ready,
  input  var rv_decode_pkg::instr_u instr,
  output var logic in_ready,
  output var logic out_valid,
  output var logic load,
  // decoded from the incoming word, for the datapath
  output var rv_decode_pkg::imm_fmt_e imm_fmt,
  output var rv_decode_pkg::op_class_e dec_class,
  output var rv_decode_pkg::branch_cond_e branch_cond,
  output var rv_decode_pkg::jump_kind_e jump_kind,
  output var logic upper_pc,
  // held for the execute side
  output var rv_decode_pkg::op_class_e op_class,
  output var rv_decode_pkg::alu_op_e alu_op,
  output var logic [`REG_ADDR_W-1:0] rd,
  output var logic [2:0] mem_funct3
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic f7_base;
  logic f7_alt;
  logic shamt_ok;
  logic no_rd;
  logic mem_op;
  rv_decode_pkg::alu_op_e f3_alu;
  rv_decode_pkg::alu_op_e dec_alu;

  assign opcode  = instr.r.opcode;
  assign funct3  = instr.r.funct3;
  assign f7_base = instr.r.funct7 == `FUNCT7_BASE;
  assign f7_alt  = instr.r.funct7 == `FUNCT7_ALT;

  // immediate shifts carry funct7 in the upper immediate bits
  assign shamt_ok = (funct3 == 3'b001) ? f7_base :
                    (funct3 == 3'b101) ? (f7_base || f7_alt) : 1'b1;

  always_comb begin
    case (funct3)
      3'b000:  f3_alu = rv_decode_pkg::alu_add;
      3'b001:  f3_alu = rv_decode_pkg::alu_sll;
      3'b010:  f3_alu = rv_decode_pkg::alu_slt;
      3'b011:  f3_alu = rv_decode_pkg::alu_sltu;
      3'b100:  f3_alu = rv_decode_pkg::alu_xor;
      3'b101:  f3_alu = rv_decode_pkg::alu_srl;
      3'b110:  f3_alu = rv_decode_pkg::alu_or;
      default: f3_alu = rv_decode_pkg::alu_and;
    endcase
  end

  // anything not matched below stays illegal
  always_comb begin
    dec_class   = rv_decode_pkg::class_illegal;
    dec_alu     = rv_decode_pkg::alu_add;
    imm_fmt     = rv_decode_pkg::imm_none;
    branch_cond = rv_decode_pkg::cond_beq;
    jump_kind   = rv_decode_pkg::jump_none;
    upper_pc    = 1'b0;
    case (opcode)
      `OPC_LUI, `OPC_AUIPC: begin
        dec_class = rv_decode_pkg::class_alu;
        imm_fmt   = rv_decode_pkg::imm_u;
        upper_pc  = opcode == `OPC_AUIPC;
      end
      `OPC_JAL: begin
        dec_class = rv_decode_pkg::class_jump;
        imm_fmt   = rv_decode_pkg::imm_j;
        jump_kind = rv_decode_pkg::jump_jal;
      end
      `OPC_JALR: if (funct3 == 3'b000) begin
        dec_class = rv_decode_pkg::class_jump;
        imm_fmt   = rv_decode_pkg::imm_i;
        jump_kind = rv_decode_pkg::jump_jalr;
      end
      `OPC_BRANCH: if (funct3[2:1] != 2'b01) begin
        dec_class   = rv_decode_pkg::class_branch;
        imm_fmt     = rv_decode_pkg::imm_b;
        branch_cond = rv_decode_pkg::branch_cond_e'(funct3);
      end
      `OPC_LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
        dec_class = rv_decode_pkg::class_load;
        imm_fmt   = rv_decode_pkg::imm_i;
      end
      `OPC_STORE: if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
        dec_class = rv_decode_pkg::class_store;
        imm_fmt   = rv_decode_pkg::imm_s;
      end
      `OPC_OP_IMM: if (shamt_ok) begin
        dec_class = rv_decode_pkg::class_alu;
        imm_fmt   = rv_decode_pkg::imm_i;
        dec_alu   = f3_alu;
        if (funct3 == 3'b101 && f7_alt) begin
          dec_alu = rv_decode_pkg::alu_sra;
        end
      end
      `OPC_OP: begin
        if (f7_base) begin
          dec_class = rv_decode_pkg::class_alu;
          dec_alu   = f3_alu;
        end else if (f7_alt && funct3 == 3'b000) begin
          dec_class = rv_decode_pkg::class_alu;
          dec_alu   = rv_decode_pkg::alu_sub;
        end else if (f7_alt && funct3 == 3'b101) begin
          dec_class = rv_decode_pkg::class_alu;
          dec_alu   = rv_decode_pkg::alu_sra;
        end
      end
      default: ;
    endcase
  end

  // a slot frees up when empty or when the execute side takes it
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  assign no_rd  = dec_class == rv_decode_pkg::class_branch ||
                  dec_class == rv_decode_pkg::class_store ||
                  dec_class == rv_decode_pkg::class_illegal;
  assign mem_op = dec_class == rv_decode_pkg::class_load ||
                  dec_class == rv_decode_pkg::class_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_class   <= rv_decode_pkg::class_alu;
      alu_op     <= rv_decode_pkg::alu_add;
      rd         <= '0;
      mem_funct3 <= 3'b000;
    end else if (load) begin
      op_class   <= dec_class;
      alu_op     <= dec_alu;
      rd         <= no_rd ? '0 : instr.r.rd;
      mem_funct3 <= mem_op ? funct3 : 3'b000;
    end
  end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module imm_gen (
  input  var rv_decode_pkg::instr_u instr,
  input  var rv_decode_pkg::imm_fmt_e imm_fmt,
  output var logic [`XLEN-1:0] imm
);

  logic sign;

  // the sign bit sits at instr[31] in every format
  assign sign = instr.r.funct7[6];

  always_comb begin
    case (imm_fmt)
      rv_decode_pkg::imm_i: begin
        imm = {{20{sign}}, instr.i.imm_11_0};
      end
      rv_decode_pkg::imm_s: begin
        imm = {{20{sign}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      rv_decode_pkg::imm_b: begin
        imm = {{19{sign}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      rv_decode_pkg::imm_u: begin
        // upper 20 bits, low part zero
        imm = {instr.u.imm_31_12, 12'b0};
      end
      rv_decode_pkg::imm_j: begin
        imm = {{11{sign}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/operand_mux.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module operand_mux (
  input  var logic clk,
  input  var logic reset,
  input  var logic load,
  input  var rv_decode_pkg::op_class_e op_class,
  input  var rv_decode_pkg::jump_kind_e jump_kind,
  // u format marks lui and auipc, i format marks register-immediate ops
  input  var rv_decode_pkg::imm_fmt_e imm_fmt,
  input  var logic upper_pc,
  input  var logic [`XLEN-1:0] imm,
  input  var logic [`XLEN-1:0] pc,
  input  var logic [`XLEN-1:0] rs1_value,
  input  var logic [`XLEN-1:0] rs2_value,
  output var logic [`XLEN-1:0] operand_a,
  output var logic [`XLEN-1:0] operand_b,
  output var logic [`XLEN-1:0] mem_addr,
  output var logic [`XLEN-1:0] store_data
);

  logic [`XLEN-1:0] a_next;
  logic [`XLEN-1:0] b_next;
  logic [`XLEN-1:0] addr_next;
  logic [`XLEN-1:0] data_next;
  logic [`XLEN-1:0] eff_addr;

  assign eff_addr = rs1_value + imm;

  always_comb begin
    a_next    = rs1_value;
    b_next    = rs2_value;
    addr_next = '0;
    data_next = '0;
    if (jump_kind != rv_decode_pkg::jump_none) begin
      // link value is formed by the execute adder
      a_next = pc;
      b_next = `XLEN'(`PC_STEP);
    end else begin
      case (op_class)
        rv_decode_pkg::class_alu: begin
          if (imm_fmt == rv_decode_pkg::imm_u) begin
            a_next = upper_pc ? pc : '0;
            b_next = imm;
          end else if (imm_fmt == rv_decode_pkg::imm_i) begin
            b_next = imm;
          end
        end
        rv_decode_pkg::class_load: begin
          addr_next = eff_addr;
        end
        rv_decode_pkg::class_store: begin
          addr_next = eff_addr;
          data_next = rs2_value;
        end
        default: begin
          a_next = '0;
          b_next = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      operand_a  <= '0;
      operand_b  <= '0;
      mem_addr   <= '0;
      store_data <= '0;
    end else if (load) begin
      operand_a  <= a_next;
      operand_b  <= b_next;
      mem_addr   <= addr_next;
      store_data <= data_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/next_pc_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module next_pc_unit (
  input  var logic clk,
  input  var logic reset,
  input  var logic load,
  input  var rv_decode_pkg::op_class_e op_class,
  input  var rv_decode_pkg::branch_cond_e branch_cond,
  input  var rv_decode_pkg::jump_kind_e jump_kind,
  input  var logic [`XLEN-1:0] imm,
  input  var logic [`XLEN-1:0] pc,
  input  var logic [`XLEN-1:0] rs1_value,
  input  var logic [`XLEN-1:0] rs2_value,
  output var logic [`XLEN-1:0] next_pc
);

  logic eq;
  logic lt_s;
  logic lt_u;
  logic taken;
  logic [`XLEN-1:0] jalr_sum;
  logic [`XLEN-1:0] pc_next;

  assign eq   = rs1_value == rs2_value;
  assign lt_s = $signed(rs1_value) < $signed(rs2_value);
  assign lt_u = rs1_value < rs2_value;

  always_comb begin
    case (branch_cond)
      rv_decode_pkg::cond_beq:  taken = eq;
      rv_decode_pkg::cond_bne:  taken = !eq;
      rv_decode_pkg::cond_blt:  taken = lt_s;
      rv_decode_pkg::cond_bge:  taken = !lt_s;
      rv_decode_pkg::cond_bltu: taken = lt_u;
      rv_decode_pkg::cond_bgeu: taken = !lt_u;
      default:                  taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_value + imm;

  always_comb begin
    if (jump_kind == rv_decode_pkg::jump_jalr) begin
      // target lsb is always dropped
      pc_next = {jalr_sum[`XLEN-1:1], 1'b0};
    end else if (jump_kind == rv_decode_pkg::jump_jal ||
                 (op_class == rv_decode_pkg::class_branch && taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + `XLEN'(`PC_STEP);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      next_pc <= '0;
    end else if (load) begin
      next_pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module decode_stage (
  input  var logic clk,
  input  var logic reset,
  // fetch side
  input  var logic in_valid,
  output var logic in_ready,
  input  var rv_decode_pkg::instr_u instr,
  input  var logic [`XLEN-1:0] pc,
  input  var logic [`XLEN-1:0] rs1_value,
  input  var logic [`XLEN-1:0] rs2_value,
  // execute side
  output var logic out_valid,
  input  var logic out_ready,
  output var rv_decode_pkg::op_class_e op_class,
  output var rv_decode_pkg::alu_op_e alu_op,
  output var logic [`REG_ADDR_W-1:0] rd,
  output var logic [2:0] mem_funct3,
  output var logic [`XLEN-1:0] operand_a,
  output var logic [`XLEN-1:0] operand_b,
  output var logic [`XLEN-1:0] mem_addr,
  output var logic [`XLEN-1:0] store_data,
  output var logic [`XLEN-1:0] next_pc
);

  logic load;
  logic upper_pc;
  logic [`XLEN-1:0] imm;
  rv_decode_pkg::imm_fmt_e imm_fmt;
  rv_decode_pkg::op_class_e dec_class;
  rv_decode_pkg::branch_cond_e branch_cond;
  rv_decode_pkg::jump_kind_e jump_kind;

  decode_control control0 (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .out_ready   (out_ready),
    .instr       (instr),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .load        (load),
    .imm_fmt     (imm_fmt),
    .dec_class   (dec_class),
    .branch_cond (branch_cond),
    .jump_kind   (jump_kind),
    .upper_pc    (upper_pc),
    .op_class    (op_class),
    .alu_op      (alu_op),
    .rd          (rd),
    .mem_funct3  (mem_funct3)
  );

  imm_gen imm0 (
    .instr   (instr),
    .imm_fmt (imm_fmt),
    .imm     (imm)
  );

  operand_mux operands0 (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .op_class   (dec_class),
    .jump_kind  (jump_kind),
    .imm_fmt    (imm_fmt),
    .upper_pc   (upper_pc),
    .imm        (imm),
    .pc         (pc),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .mem_addr   (mem_addr),
    .store_data (store_data)
  );

  next_pc_unit npc0 (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .op_class    (dec_class),
    .branch_cond (branch_cond),
    .jump_kind   (jump_kind),
    .imm         (imm),
    .pc          (pc),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .next_pc     (next_pc)
  );

endmodule

`default_nettype wire

// File: tests/decode_stage_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module decode_stage_checker (
  input var logic clk,
  input var logic reset,
  input var logic in_ready,
  input var logic out_valid,
  input var logic out_ready,
  input var logic [2:0] op_class,
  input var logic [3:0] alu_op,
  input var logic [`REG_ADDR_W-1:0] rd,
  input var logic [2:0] mem_funct3,
  input var logic [`XLEN-1:0] operand_a,
  input var logic [`XLEN-1:0] operand_b,
  input var logic [`XLEN-1:0] mem_addr,
  input var logic [`XLEN-1:0] store_data,
  input var logic [`XLEN-1:0] next_pc
);

  // every execute-side output in one word
  logic [5*`XLEN+`REG_ADDR_W+9:0] held;

  assign held = {op_class, alu_op, rd, mem_funct3, operand_a, operand_b,
                 mem_addr, store_data, next_pc};

  after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // stalled result must not move
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(held))
    else $error("execute-side outputs changed while stalled");

  ready_rule: assert property (@(posedge clk) disable iff (reset)
    in_ready == (!out_valid || out_ready))
    else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind decode_stage decode_stage_checker checker0 (
  .clk        (clk),
  .reset      (reset),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .op_class   (op_class),
  .alu_op     (alu_op),
  .rd         (rd),
  .mem_funct3 (mem_funct3),
  .operand_a  (operand_a),
  .operand_b  (operand_b),
  .mem_addr   (mem_addr),
  .store_data (store_data),
  .next_pc    (next_pc)
);

`default_nettype wire

// File: tests/decode_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module decode_stage_tb;

  localparam int ROWS = 27;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 16;

  typedef struct {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    rv_decode_pkg::op_class_e cls;
    rv_decode_pkg::alu_op_e alu;
    logic [31:0] rd;
    logic [31:0] funct3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] npc;
  } row_t;

  logic clk;
  logic reset;
  logic in_valid;
  logic in_ready;
  rv_decode_pkg::instr_u instr;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rs1_value;
  logic [`XLEN-1:0] rs2_value;
  logic out_valid;
  logic out_ready;
  rv_decode_pkg::op_class_e op_class;
  rv_decode_pkg::alu_op_e alu_op;
  logic [`REG_ADDR_W-1:0] rd;
  logic [2:0] mem_funct3;
  logic [`XLEN-1:0] operand_a;
  logic [`XLEN-1:0] operand_b;
  logic [`XLEN-1:0] mem_addr;
  logic [`XLEN-1:0] store_data;
  logic [`XLEN-1:0] next_pc;

  row_t rows [ROWS];
  int row_count;
  int expect_q [$];
  int sent;
  int received;
  int errors;
  int idx;

  decode_stage dut0 (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .instr      (instr),
    .pc         (pc),
    .rs1_value  (rs1_value),
    .rs2_value  (rs2_value),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .op_class   (op_class),
    .alu_op     (alu_op),
    .rd         (rd),
    .mem_funct3 (mem_funct3),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .next_pc    (next_pc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // instruction word builders, one per base format
  function automatic logic [31:0] r_type(input logic [31:0] f7, input logic [31:0] rs2,
      input logic [31:0] rs1, input logic [31:0] f3, input logic [31:0] rdi,
      input logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rdi[4:0], opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [31:0] rs1,
      input logic [31:0] f3, input logic [31:0] rdi, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rdi[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [31:0] rs2,
      input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [31:0] rs2,
      input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [31:0] rdi,
      input logic [6:0] opc);
    return {imm[31:12], rdi[4:0], opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [31:0] rdi);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rdi[4:0], `OPC_JAL};
  endfunction

  task automatic add_row(input logic [31:0] w, input logic [31:0] p, input logic [31:0] r1,
      input logic [31:0] r2, input rv_decode_pkg::op_class_e c, input rv_decode_pkg::alu_op_e o,
      input logic [31:0] d, input logic [31:0] f3, input logic [31:0] a, input logic [31:0] b,
      input logic [31:0] addr, input logic [31:0] data, input logic [31:0] npc);
    rows[row_count] = '{w, p, r1, r2, c, o, d, f3, a, b, addr, data, npc};
    row_count++;
  endtask

  task automatic check_value(input string name, input int row, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s row %0d: expected %h, got %h", name, row, expected, actual);
      errors++;
    end
  endtask

  task automatic check_row(input int r);
    check_value("op_class", r, 32'(rows[r].cls), 32'(op_class));
    check_value("alu_op", r, 32'(rows[r].alu), 32'(alu_op));
    check_value("rd", r, rows[r].rd, 32'(rd));
    check_value("mem_funct3", r, rows[r].funct3, 32'(mem_funct3));
    check_value("operand_a", r, rows[r].a, operand_a);
    check_value("operand_b", r, rows[r].b, operand_b);
    check_value("mem_addr", r, rows[r].addr, mem_addr);
    check_value("store_data", r, rows[r].data, store_data);
    check_value("next_pc", r, rows[r].npc, next_pc);
  endtask

  task automatic fill_table();
    // register-register alu ops
    add_row(r_type(0, 2, 1, 0, 3, `OPC_OP), 'h100, 5, 7,
            rv_decode_pkg::class_alu, rv_decode_pkg::alu_add, 3, 0, 5, 7, 0, 0, 'h104);
    add_row(r_type('h20, 2, 1, 0, 4, `OPC_OP), 'h104, 10, 3,
            rv_decode_pkg::class_alu, rv_decode_pkg::alu_sub, 4, 0, 10, 3, 0, 0, 'h108);
    add_row(r_type(0, 2, 1, 2, 5, `OPC_OP), 'h108, 'hFFFFFFFF, 1, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_slt, 5, 0, 'hFFFFFFFF, 1, 0, 0, 'h10C);
    add_row(r_type(0, 2, 1, 3, 6, `OPC_OP), 'h10C, 'hFFFFFFFF, 1, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_sltu, 6, 0, 'hFFFFFFFF, 1, 0, 0, 'h110);
    add_row(r_type(0, 2, 1, 4, 7, `OPC_OP), 'h110, 'hF0F0, 'h0FF0, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_xor, 7, 0, 'hF0F0, 'h0FF0, 0, 0, 'h114);
    add_row(r_type(0, 2, 1, 6, 8, `OPC_OP), 'h114, 'hF0F0, 'h0FF0, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_or, 8, 0, 'hF0F0, 'h0FF0, 0, 0, 'h118);
    add_row(r_type(0, 2, 1, 7, 9, `OPC_OP), 'h118, 'hF0F0, 'h0FF0, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_and, 9, 0, 'hF0F0, 'h0FF0, 0, 0, 'h11C);
    add_row(r_type(0, 2, 1, 1, 10, `OPC_OP), 'h11C, 1, 4,
            rv_decode_pkg::class_alu, rv_decode_pkg::alu_sll, 10, 0, 1, 4, 0, 0, 'h120);
    add_row(r_type(0, 2, 1, 5, 11, `OPC_OP), 'h120, 'h80000000, 4, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_srl, 11, 0, 'h80000000, 4, 0, 0, 'h124);
    add_row(r_type('h20, 2, 1, 5, 12, `OPC_OP), 'h124, 'h80000000, 4, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_sra, 12, 0, 'h80000000, 4, 0, 0, 'h128);
    // immediate forms
    add_row(i_type(-5, 1, 0, 13, `OPC_OP_IMM), 'h200, 'h20, 'h99, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_add, 13, 0, 'h20, 'hFFFFFFFB, 0, 0, 'h204);
    add_row(i_type('h403, 1, 5, 14, `OPC_OP_IMM), 'h204, 'hF0000000, 'h99, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_sra, 14, 0, 'hF0000000, 'h403, 0, 0, 'h208);
    add_row(i_type('h7FF, 1, 3, 15, `OPC_OP_IMM), 'h208, 5, 'h99, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_sltu, 15, 0, 5, 'h7FF, 0, 0, 'h20C);
    // memory
    add_row(i_type(-8, 1, 2, 16, `OPC_LOAD), 'h300, 'h2000, 'h55, rv_decode_pkg::class_load,
            rv_decode_pkg::alu_add, 16, 2, 'h2000, 'h55, 'h1FF8, 0, 'h304);
    add_row(s_type('h10, 2, 1, 1), 'h304, 'h3000, 'hABCD, rv_decode_pkg::class_store,
            rv_decode_pkg::alu_add, 0, 1, 'h3000, 'hABCD, 'h3010, 'hABCD, 'h308);
    // branches, taken and not taken
    add_row(b_type('h20, 2, 1, 0), 'h400, 9, 9,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h420);
    add_row(b_type(-16, 2, 1, 1), 'h404, 9, 9,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h408);
    add_row(b_type(-'h40, 2, 1, 4), 'h800, 'hFFFFFFF0, 1,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h7C0);
    add_row(b_type('h40, 2, 1, 5), 'h804, 'hFFFFFFF0, 1,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h808);
    add_row(b_type(8, 2, 1, 6), 'h808, 'hFFFFFFF0, 1,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h80C);
    add_row(b_type('h100, 2, 1, 7), 'h80C, 'hFFFFFFF0, 1,
            rv_decode_pkg::class_branch, rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h90C);
    // jumps link through pc plus 4
    add_row(j_type('h800, 1), 'h1000, 'h11, 'h22, rv_decode_pkg::class_jump,
            rv_decode_pkg::alu_add, 1, 0, 'h1000, 4, 0, 0, 'h1800);
    add_row(i_type(3, 6, 0, 5, `OPC_JALR), 'h1800, 'h2000, 'h22, rv_decode_pkg::class_jump,
            rv_decode_pkg::alu_add, 5, 0, 'h1800, 4, 0, 0, 'h2002);
    // upper immediates
    add_row(u_type('h12345000, 7, `OPC_LUI), 'h2000, 'h33, 'h44, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_add, 7, 0, 0, 'h12345000, 0, 0, 'h2004);
    add_row(u_type('hFFFFF000, 8, `OPC_AUIPC), 'h500, 'h33, 'h44, rv_decode_pkg::class_alu,
            rv_decode_pkg::alu_add, 8, 0, 'h500, 'hFFFFF000, 0, 0, 'h504);
    // unknown opcode, then an M extension multiply
    add_row(r_type(0, 0, 0, 0, 1, 7'h7F), 'h600, 'h12, 'h34, rv_decode_pkg::class_illegal,
            rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h604);
    add_row(r_type(1, 2, 1, 0, 3, `OPC_OP), 'h604, 'h12, 'h34, rv_decode_pkg::class_illegal,
            rv_decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, 'h608);
  endtask

  // fetch side, execute side and scoreboard share one clocked process
  always @(posedge clk) begin
    if (!reset) begin
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          $display("The DUT delivered a result with no instruction outstanding");
          errors++;
        end else begin
          idx = expect_q.pop_front();
          check_row(idx);
          received++;
        end
      end
      if (in_valid && in_ready) begin
        expect_q.push_back(sent);
        sent++;
      end
      if (!in_valid || in_ready) begin
        if (sent < ROWS && $urandom_range(3) != 0) begin
          in_valid  <= 1'b1;
          instr     <= rows[sent].instr;
          pc        <= rows[sent].pc;
          rs1_value <= rows[sent].rs1;
          rs2_value <= rows[sent].rs2;
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= $urandom_range(3) != 0;
    end
  end

  initial begin
    void'($urandom(15));
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    instr = '0;
    pc = '0;
    rs1_value = '0;
    rs2_value = '0;
    out_ready = 1'b0;
    row_count = 0;
    sent = 0;
    received = 0;
    errors = 0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    while (received < ROWS) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("rows checked %0d of %0d, errors %0d", received, ROWS, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // each row gets 20 cycles on top of reset
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + ROWS * 20));
    $display("Timeout: only %0d of %0d rows came out of the DUT", received, ROWS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_decode.f
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/decode_control.sv
hdl/imm_gen.sv
hdl/operand_mux.sv
hdl/next_pc_unit.sv
hdl/decode_stage.sv
tests/decode_stage_checker.sv
tests/decode_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = decode_stage_tb
FILELIST = rv_decode.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Checks failed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
